// File: Makefile
# Verilator simulation of the fetch stage testbench
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_fetch -f list.f -o sim_fetch
	-./obj_dir/sim_fetch > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: fetch_assert.sv
// fetch stage protocol checks
// memory port stability and alignment on the cache side,
// instruction hold under decode back-pressure on the fetch unit side
// bound into icache and into fetch_unit, unused inputs tied off there

module fetch_assert (
    input  logic                         clk,
    input  logic                         rst,
    input  fetch_pkg::cache_state_e      state_i,
    input  logic                         cpu_req_i,
    input  logic [fetch_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic                         mem_valid_i,
    input  logic                         mem_ready_i,
    input  logic [31:0]                  instr_i,
    input  logic                         inst_valid_i,
    input  logic                         id_en_i
);

    // number of failed assertions
    int failures = 0;

    // request level and address hold until the ready strobe
    a_mem_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i))
        else begin
            failures++;
            $error("memory request changed before ready");
        end

    // level drops in the cycle after ready
    a_mem_drop: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && mem_ready_i |=> !mem_valid_i)
        else begin
            failures++;
            $error("memory request still up after ready");
        end

    // fetch unit only asks while the cache is idle
    a_req_idle: assert property (@(posedge clk) disable iff (rst)
        cpu_req_i |-> state_i == fetch_pkg::IDLE)
        else begin
            failures++;
            $error("fetch request while the cache is busy");
        end

    // refill always on a line boundary
    a_mem_align: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i |-> mem_addr_i[fetch_pkg::OFFSET_W-1:0] == '0)
        else begin
            failures++;
            $error("memory address not line aligned");
        end

    // held instruction stays put while decode stalls
    a_inst_hold: assert property (@(posedge clk) disable iff (rst)
        inst_valid_i && !id_en_i |=> inst_valid_i && $stable(instr_i))
        else begin
            failures++;
            $error("instruction changed while decode stalled");
        end

endmodule

bind icache fetch_assert u_cache_assert (
    .clk          (clk),
    .rst          (rst),
    .state_i      (state),
    .cpu_req_i    (cpu_req_i),
    .mem_addr_i   (mem_addr_o),
    .mem_valid_i  (mem_valid_o),
    .mem_ready_i  (mem_ready_i),
    .instr_i      (32'd0),
    .inst_valid_i (1'b0),
    .id_en_i      (1'b1)
);

bind fetch_unit fetch_assert u_fetch_assert (
    .clk          (clk),
    .rst          (rst),
    .state_i      (fetch_pkg::IDLE),
    .cpu_req_i    (1'b0),
    .mem_addr_i   (64'd0),
    .mem_valid_i  (1'b0),
    .mem_ready_i  (1'b0),
    .instr_i      (instr_o),
    .inst_valid_i (inst_valid_o),
    .id_en_i      (id_en_i)
);

// File: fetch_pkg.sv
// fetch stage shared definitions
// reset address, address and cache line geometry, cache controller states
// used by the fetch unit, the instruction cache and its tag/data store

package fetch_pkg;

    // full virtual address width of the core
    parameter int ADDR_W = 64;

    // pc value loaded by reset, start of the boot image
    parameter logic [ADDR_W-1:0] RESET_PC = 64'h8000_0000;

    // one cache line is 128 bits, i.e. four 32-bit instructions
    parameter int LINE_W = 128;

    // byte offset bits inside a line
    // 16 bytes per line -> 4 bits
    parameter int OFFSET_W = 4;

    // cache controller FSM
    // IDLE    waiting for a request from the fetch unit
    // LOOKUP  array read and tag compare for the latched address
    // REFILL  memory request held until the line comes back
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        REFILL = 2'd2
    } cache_state_e;

endpackage

// File: fetch_top.sv
// fetch stage top level
// fetch unit in front of the instruction cache
// the cache refills over a level/strobe memory port
// LINES sets the number of cache sets and is passed down

module fetch_top #(
    parameter int LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    // pipeline side
    input  logic                         dnpc_valid_i,
    input  logic                         block_i,
    input  logic [fetch_pkg::ADDR_W-1:0] dnpc_i,
    input  logic                         id_en_i,
    output logic [fetch_pkg::ADDR_W-1:0] pc_o,
    output logic [31:0]                  instr_o,
    output logic                         inst_valid_o,
    // memory side
    output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                         mem_valid_o,
    input  logic [fetch_pkg::LINE_W-1:0] mem_data_i,
    input  logic                         mem_ready_i
);

    // fetch unit to cache
    logic [fetch_pkg::ADDR_W-1:0] cpu_addr;
    logic                         cpu_req;
    logic [63:0]                  cpu_word;
    logic                         cpu_ready;

    // request address is the current pc
    assign cpu_addr = pc_o;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst          (rst),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .dnpc_i       (dnpc_i),
        .id_en_i      (id_en_i),
        .cpu_word_i   (cpu_word),
        .cpu_ready_i  (cpu_ready),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .inst_valid_o (inst_valid_o),
        .cpu_req_o    (cpu_req)
    );

    icache #(
        .LINES (LINES)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr_i  (cpu_addr),
        .cpu_req_i   (cpu_req),
        .cpu_word_o  (cpu_word),
        .cpu_ready_o (cpu_ready),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_o (mem_valid_o),
        .mem_data_i  (mem_data_i),
        .mem_ready_i (mem_ready_i)
    );

endmodule

// File: fetch_unit.sv
// instruction fetch unit
// holds the pc, issues one cache request per pc value and drops words
// that come back for a pc that was already replaced
// the selected 32-bit instruction is held until decode takes it

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,
    // next pc from the pipeline
    input  logic                         dnpc_valid_i,
    input  logic                         block_i,
    input  logic [fetch_pkg::ADDR_W-1:0] dnpc_i,
    // decode acceptance
    input  logic                         id_en_i,
    // cache return
    input  logic [63:0]                  cpu_word_i,
    input  logic                         cpu_ready_i,
    output logic [fetch_pkg::ADDR_W-1:0] pc_o,
    output logic [31:0]                  instr_o,
    output logic                         inst_valid_o,
    output logic                         cpu_req_o
);

    // pc update enable
    logic pc_en;

    // a request is in flight, either just pulsed or waiting on the cache
    logic busy;
    logic pending_q;

    // in-flight request belongs to an older pc
    logic stale_q;

    // returned word is kept
    logic accept;

    // instruction half picked by pc bit 2
    logic [31:0] instr_sel;

    assign pc_en     = dnpc_valid_i & ~block_i;
    assign busy      = cpu_req_o | pending_q;
    // a word returning while the pc moves is also for the old pc
    assign accept    = cpu_ready_i & ~stale_q & ~pc_en;
    assign instr_sel = pc_o[2] ? cpu_word_i[63:32] : cpu_word_i[31:0];

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o <= fetch_pkg::RESET_PC;
        end else if (pc_en) begin
            pc_o <= dnpc_i;
        end
    end

    // request pulse
    // set during reset so the first cycle after release fetches RESET_PC
    // a pc update asks again once the cache is free, otherwise the
    // request is deferred until the stale word has come back
    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_req_o <= 1'b1;
        end else begin
            cpu_req_o <= (pc_en & (~busy | cpu_ready_i)) | (stale_q & cpu_ready_i);
        end
    end

    // outstanding request tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (cpu_req_o) begin
            pending_q <= 1'b1;
        end else if (cpu_ready_i) begin
            pending_q <= 1'b0;
        end
    end

    // stale flag, cleared by the return it marks
    always_ff @(posedge clk) begin
        if (rst) begin
            stale_q <= 1'b0;
        end else if (cpu_ready_i) begin
            stale_q <= 1'b0;
        end else if (pc_en && busy) begin
            stale_q <= 1'b1;
        end
    end

    // valid flag
    // holds while decode stalls, clears once decode takes the instruction
    // unless a new one arrives in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid_o <= 1'b0;
        end else if (accept) begin
            inst_valid_o <= 1'b1;
        end else if (id_en_i) begin
            inst_valid_o <= 1'b0;
        end
    end

    // instruction payload
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_o <= instr_sel;
        end
    end

endmodule

// File: icache.sv
// read-only direct-mapped instruction cache controller
// latches a fetch request, looks it up in the store and returns
// the 64-bit half of the line picked by address bit 3
// on a miss the whole line is fetched from memory with a level request
// held until the ready strobe, then the lookup is repeated

module icache #(
    parameter int LINES = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    // fetch unit side
    input  logic [fetch_pkg::ADDR_W-1:0]  cpu_addr_i,
    input  logic                          cpu_req_i,
    output logic [63:0]                   cpu_word_o,
    output logic                          cpu_ready_o,
    // memory side
    output logic [fetch_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic                          mem_valid_o,
    input  logic [fetch_pkg::LINE_W-1:0]  mem_data_i,
    input  logic                          mem_ready_i
);

    localparam int IDX_W    = $clog2(LINES);
    localparam int LADDR_W  = fetch_pkg::ADDR_W - fetch_pkg::OFFSET_W;
    localparam int TAG_W    = LADDR_W - IDX_W;
    localparam int HALF_W   = fetch_pkg::LINE_W / 2;

    // controller state
    fetch_pkg::cache_state_e state;
    fetch_pkg::cache_state_e state_d;

    // latched request, line address and word half select
    logic [LADDR_W-1:0] line_addr_q;
    logic               half_q;

    // store interface
    logic [IDX_W-1:0]            st_index;
    logic [TAG_W-1:0]            st_tag;
    logic                        st_wr_en;
    logic                        st_hit;
    logic [fetch_pkg::LINE_W-1:0] st_line;

    // request is taken only while idle
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::IDLE && cpu_req_i) begin
            line_addr_q <= cpu_addr_i[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W];
            half_q      <= cpu_addr_i[3];
        end
    end

    // next state
    always_comb begin
        state_d = state;
        case (state)
            fetch_pkg::IDLE: begin
                if (cpu_req_i) begin
                    state_d = fetch_pkg::LOOKUP;
                end
            end
            fetch_pkg::LOOKUP: begin
                // hit returns this cycle, miss goes out to memory
                if (st_hit) begin
                    state_d = fetch_pkg::IDLE;
                end else begin
                    state_d = fetch_pkg::REFILL;
                end
            end
            fetch_pkg::REFILL: begin
                // line lands in the store at this edge, look it up again
                if (mem_ready_i) begin
                    state_d = fetch_pkg::LOOKUP;
                end
            end
            default: begin
                state_d = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::IDLE;
        end else begin
            state <= state_d;
        end
    end

    // set index from the low line address bits, tag from the rest
    assign st_index = line_addr_q[IDX_W-1:0];
    assign st_tag   = line_addr_q[LADDR_W-1:IDX_W];

    // write the refilled line in the ready cycle
    assign st_wr_en = (state == fetch_pkg::REFILL) && mem_ready_i;

    icache_store #(
        .LINES (LINES)
    ) u_store (
        .clk       (clk),
        .rst       (rst),
        .index_i   (st_index),
        .tag_i     (st_tag),
        .wr_en_i   (st_wr_en),
        .wr_line_i (mem_data_i),
        .hit_o     (st_hit),
        .line_o    (st_line)
    );

    // one-cycle ready strobe, only a lookup hit answers the fetch unit
    assign cpu_ready_o = (state == fetch_pkg::LOOKUP) && st_hit;

    // address bit 3 picks the upper or lower half of the line
    assign cpu_word_o = half_q ? st_line[fetch_pkg::LINE_W-1:HALF_W]
                               : st_line[HALF_W-1:0];

    // memory request is a level for the whole refill
    // address is line aligned and cannot move since line_addr_q
    // only loads in IDLE
    assign mem_valid_o = (state == fetch_pkg::REFILL);
    assign mem_addr_o  = {line_addr_q, {fetch_pkg::OFFSET_W{1'b0}}};

endmodule

// File: icache_store.sv
// instruction cache storage
// direct-mapped valid, tag and data arrays with asynchronous read
// compares the stored tag of the addressed set with the incoming tag
// a write fills a whole line and marks the set valid

module icache_store #(
    parameter int LINES = 16
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [$clog2(LINES)-1:0]              index_i,
    input  logic [fetch_pkg::ADDR_W-fetch_pkg::OFFSET_W-$clog2(LINES)-1:0] tag_i,
    input  logic                                  wr_en_i,
    input  logic [fetch_pkg::LINE_W-1:0]          wr_line_i,
    output logic                                  hit_o,
    output logic [fetch_pkg::LINE_W-1:0]          line_o
);

    // set index and tag widths follow from the number of sets
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = fetch_pkg::ADDR_W - fetch_pkg::OFFSET_W - IDX_W;

    // one valid bit per set
    logic [LINES-1:0] valid_q;

    // tag and line storage, no reset needed
    logic [TAG_W-1:0]            tag_mem  [LINES];
    logic [fetch_pkg::LINE_W-1:0] data_mem [LINES];

    // stored tag of the addressed set
    logic [TAG_W-1:0] rd_tag;

    // valid bits start cleared so every set misses after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    // refill writes tag and line together
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[index_i]  <= tag_i;
            data_mem[index_i] <= wr_line_i;
        end
    end

    // combinational read of the set
    assign rd_tag = tag_mem[index_i];
    assign line_o = data_mem[index_i];

    // hit only on a valid set with matching tag
    assign hit_o = valid_q[index_i] && (rd_tag == tag_i);

endmodule

// File: list.f
fetch_pkg.sv
icache_store.sv
icache.sv
fetch_unit.sv
fetch_top.sv
fetch_assert.sv
tb_fetch.sv

// File: tb_fetch.sv
// testbench for the fetch stage
// memory model answers refills with a random delay, decode stalls at random
// every accepted instruction is compared with the expected pc and word

module tb_fetch;

    localparam int LINES    = 16;
    localparam int IDX_W    = $clog2(LINES);
    localparam int WAIT_MAX = 200;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          dnpc_valid_i;
    logic                          block_i;
    logic [fetch_pkg::ADDR_W-1:0]  dnpc_i;
    logic                          id_en_i;
    logic [fetch_pkg::ADDR_W-1:0]  pc_o;
    logic [31:0]                   instr_o;
    logic                          inst_valid_o;
    logic [fetch_pkg::ADDR_W-1:0]  mem_addr_o;
    logic                          mem_valid_o;
    logic [fetch_pkg::LINE_W-1:0]  mem_data_i;
    logic                          mem_ready_i;

    // pcs whose instruction must be accepted next, oldest first
    logic [63:0] exp_q[$];
    logic [63:0] exp_pc;
    int          errors;
    int          checks;
    int          delivered;
    int          mem_reqs;
    int          exp_reqs;

    // random source, memory responder state, stall enable
    logic [31:0] lfsr;
    logic [2:0]  rnd;
    logic        resp_busy;
    logic [2:0]  resp_delay;
    logic        stall_on;

    // lines the cache should hold, one entry per set
    logic [59:0] res_line [LINES];
    logic        res_valid[LINES];

    fetch_top #(
        .LINES (LINES)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .dnpc_i       (dnpc_i),
        .id_en_i      (id_en_i),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .inst_valid_o (inst_valid_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_o  (mem_valid_o),
        .mem_data_i   (mem_data_i),
        .mem_ready_i  (mem_ready_i)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // memory contents, a pure function of the byte address
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        return addr[31:0] ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [fetch_pkg::LINE_W-1:0] make_line(input logic [63:0] base);
        logic [fetch_pkg::LINE_W-1:0] data;
        for (int k = 0; k < fetch_pkg::LINE_W / 32; k++) begin
            data[32*k +: 32] = mem_word(base + 64'(4 * k));
        end
        return data;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [2:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[1:0], lfsr[0]};
        end
    endtask

    // a fetch of a line not resident in its set costs one refill
    task automatic note_fetch(input logic [63:0] addr);
        int idx;
        idx = int'(addr[fetch_pkg::OFFSET_W +: IDX_W]);
        if (!res_valid[idx] || res_line[idx] != addr[63:4]) begin
            exp_reqs++;
        end
        res_valid[idx] = 1'b1;
        res_line[idx]  = addr[63:4];
    endtask

    task automatic finish_run();
        // bound protocol checks count as errors too
        errors += u_dut.u_icache.u_cache_assert.failures
                + u_dut.u_fetch_unit.u_fetch_assert.failures;
        $display("checks %0d, errors %0d, instructions %0d, memory requests %0d of %0d",
                 checks, errors, delivered, mem_reqs, exp_reqs);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic wait_delivered();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("timeout: instruction for pc %h never accepted", exp_q[0]);
            finish_run();
        end
    endtask

    // pc update pulse, then wait for its instruction
    task automatic step_pc(input logic [63:0] addr);
        dnpc_valid_i = 1'b1;
        dnpc_i       = addr;
        exp_q.push_back(addr);
        note_fetch(addr);
        @(negedge clk);
        dnpc_valid_i = 1'b0;
        wait_delivered();
    endtask

    // jump away while the refill for old_pc is still out
    task automatic redirect_fetch(input logic [63:0] old_pc, input logic [63:0] new_pc);
        int n;
        dnpc_valid_i = 1'b1;
        dnpc_i       = old_pc;
        note_fetch(old_pc);
        @(negedge clk);
        dnpc_valid_i = 1'b0;
        n = 0;
        while (!mem_valid_o && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        assert (mem_valid_o) else begin
            errors++;
            $display("timeout: no memory request for pc %h", old_pc);
            finish_run();
        end
        step_pc(new_pc);
    endtask

    // decode stalls and memory responder share one random stream
    always @(negedge clk) begin
        if (stall_on) begin
            draw_bits(1, rnd);
            id_en_i = rnd[0];
        end else begin
            id_en_i = 1'b1;
        end
        if (rst) begin
            mem_ready_i = 1'b0;
            resp_busy   = 1'b0;
        end else if (mem_ready_i) begin
            mem_ready_i = 1'b0;
            resp_busy   = 1'b0;
        end else begin
            if (!resp_busy && mem_valid_o) begin
                resp_busy = 1'b1;
                mem_reqs++;
                draw_bits(3, resp_delay);
            end
            if (resp_busy) begin
                if (resp_delay == 3'd0) begin
                    mem_data_i  = make_line(mem_addr_o);
                    mem_ready_i = 1'b1;
                end else begin
                    resp_delay = resp_delay - 3'd1;
                end
            end
        end
    end

    // compare each accepted instruction with the oldest expected pc
    always @(posedge clk) begin
        if (!rst && inst_valid_o && id_en_i) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("unexpected instruction %h for pc %h at %0t", instr_o, pc_o, $time);
            end
            if (exp_q.size() != 0) begin
                exp_pc = exp_q.pop_front();
                delivered++;
                assert (pc_o == exp_pc) else begin
                    errors++;
                    $display("MISMATCH at %0t: pc_o = %h, expected %h", $time, pc_o, exp_pc);
                end
                assert (instr_o == mem_word(exp_pc)) else begin
                    errors++;
                    $display("MISMATCH at %0t: instr_o = %h, expected %h",
                             $time, instr_o, mem_word(exp_pc));
                end
            end
        end
    end

    initial begin
        logic [63:0] held_pc;
        rst          = 1'b1;
        dnpc_valid_i = 1'b0;
        block_i      = 1'b0;
        dnpc_i       = '0;
        id_en_i      = 1'b1;
        mem_data_i   = '0;
        mem_ready_i  = 1'b0;
        lfsr         = 32'hf234_087d;
        stall_on     = 1'b0;
        resp_busy    = 1'b0;
        resp_delay   = '0;
        errors       = 0;
        checks       = 0;
        delivered    = 0;
        mem_reqs     = 0;
        exp_reqs     = 0;
        for (int s = 0; s < LINES; s++) begin
            res_valid[s] = 1'b0;
            res_line[s]  = '0;
        end

        // the boot fetch starts on its own once reset drops
        exp_q.push_back(fetch_pkg::RESET_PC);
        note_fetch(fetch_pkg::RESET_PC);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        checks++;
        assert (pc_o == fetch_pkg::RESET_PC && !inst_valid_o) else begin
            errors++;
            $display("MISMATCH at %0t: pc_o = %h inst_valid_o = %b, expected %h and 0",
                     $time, pc_o, inst_valid_o, fetch_pkg::RESET_PC);
        end
        wait_delivered();

        // sequential words through the second line
        for (int i = 1; i < 8; i++) begin
            step_pc(fetch_pkg::RESET_PC + 64'(4 * i));
        end

        // only the target of the jump may show up
        held_pc = 64'h8001_2348;
        redirect_fetch(64'h8000_4024, held_pc);

        // blocked updates leave the pc alone
        block_i      = 1'b1;
        dnpc_valid_i = 1'b1;
        dnpc_i       = 64'h9000_0000;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            checks++;
            assert (pc_o == held_pc) else begin
                errors++;
                $display("MISMATCH at %0t: pc_o = %h, expected %h", $time, pc_o, held_pc);
            end
        end
        block_i      = 1'b0;
        dnpc_valid_i = 1'b0;

        // random decode stalls, stall flag flips between edges
        @(posedge clk);
        stall_on = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            step_pc(64'h8000_1000 + 64'(4 * i));
        end
        @(posedge clk);
        stall_on = 1'b0;
        @(negedge clk);

        // same set, different tags, each one evicts the other
        for (int i = 0; i < 4; i++) begin
            step_pc((i % 2 == 0) ? 64'h8000_2004 : 64'h8000_2004 + 64'(LINES * 16));
        end

        checks++;
        assert (mem_reqs == exp_reqs) else begin
            errors++;
            $display("MISMATCH at %0t: memory requests = %0d, expected %0d",
                     $time, mem_reqs, exp_reqs);
        end
        finish_run();
    end

endmodule
